// ==== sim.f ====
+incdir+include
hw/he_pkg.sv
hw/he_csr_regs.sv
hw/he_dma_engine.sv
hw/he_poly_bank.sv
hw/he_mod_add.sv
hw/he_sequencer.sv
hw/he_accel_top.sv
tests/he_accel_sva.sv
tests/he_accel_tb.sv

// ==== Bender.yml ====
package:
  name: he_accel

sources:
  - include_dirs:
      - include
    files:
      - hw/he_pkg.sv
      - hw/he_csr_regs.sv
      - hw/he_dma_engine.sv
      - hw/he_poly_bank.sv
      - hw/he_mod_add.sv
      - hw/he_sequencer.sv
      - hw/he_accel_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/he_accel_sva.sv
      - tests/he_accel_tb.sv

// ==== tests/he_accel_tb.sv ====
`default_nettype none
`include "he_defs.svh"

module he_accel_tb;

   localparam int csr_wait_lp   = 8;
   localparam int done_polls_lp = 2000;

   logic                  clk_i;
   logic                  reset_i;
   logic                  csr_v_i;
   he_pkg::csr_req_s      csr_req_i;
   logic                  csr_rsp_v_o;
   logic [`HE_DATA_W-1:0] csr_rsp_data_o;
   logic                  mem_cmd_v_o;
   he_pkg::mem_cmd_s      mem_cmd_o;
   logic                  mem_rsp_v_i;
   he_pkg::mem_rsp_s      mem_rsp_i;

   // sparse backing store and the write addresses of the current run
   logic [`HE_DATA_W-1:0] mem [logic [`HE_ADDR_W-1:0]];
   logic [`HE_ADDR_W-1:0] wr_log [$];
   he_pkg::mem_cmd_s      last_cmd;
   logic                  rsp_pending;
   int                    rsp_delay;
   logic [`HE_DATA_W-1:0] rsp_data;
   int                    tb_errs;

   he_accel_top dut_i (.clk_i, .reset_i, .csr_v_i, .csr_req_i, .csr_rsp_v_o, .csr_rsp_data_o,
      .mem_cmd_v_o, .mem_cmd_o, .mem_rsp_v_i, .mem_rsp_i);

   initial
   begin
      clk_i = 1'b0;
      forever
         #50 clk_i = ~clk_i;
   end

   // unwritten words read as a pattern of their full address
   function automatic logic [`HE_DATA_W-1:0] read_word(input logic [`HE_ADDR_W-1:0] addr);
      if (mem.exists(addr))
         return mem[addr];
      return addr[31:0] ^ {4{addr[39:32]}};
   endfunction

   ////////////////////////////////////////
   // memory model

   always @(posedge clk_i)
   begin
      if (reset_i)
      begin
         mem_rsp_v_i <= 1'b0;
         rsp_pending = 1'b0;
      end
      else
      begin
         mem_rsp_v_i <= 1'b0;
         if (rsp_pending)
         begin
            rsp_delay--;
            if (rsp_delay == 0)
            begin
               mem_rsp_v_i <= 1'b1;
               mem_rsp_i   <= '{data: rsp_data};
               rsp_pending = 1'b0;
            end
         end
         if (mem_cmd_v_o)
         begin
            last_cmd    = mem_cmd_o;
            rsp_pending = 1'b1;
            rsp_delay   = $urandom_range(4, 1);
            rsp_data    = '0;
            if (mem_cmd_o.wr)
            begin
               mem[mem_cmd_o.addr] = mem_cmd_o.data;
               wr_log.push_back(mem_cmd_o.addr);
            end
            else
               rsp_data = read_word(mem_cmd_o.addr);
         end
      end
   end

   ////////////////////////////////////////
   // checks and CSR access

   task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         tb_errs++;
         $display("FAIL %s got %0h expected %0h", name, got, exp);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond)
      else
      begin
         tb_errs++;
         $display("%s", what);
      end
   endtask

   task automatic finish_run();
      int sva_errs;
      sva_errs = dut_i.sva_i.fail_cnt;
      $display("errors: %0d testbench, %0d assertion", tb_errs, sva_errs);
      if (tb_errs == 0 && sva_errs == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   endtask

   task automatic csr_xfer(input logic is_wr, input he_pkg::csr_addr_e reg_addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
      int   waited;
      logic got;
      @(posedge clk_i);
      csr_v_i   <= 1'b1;
      csr_req_i <= '{wr: is_wr, addr: reg_addr, data: wdata};
      @(posedge clk_i);
      csr_v_i <= 1'b0;
      waited = 0;
      got    = 1'b0;
      rdata  = '0;
      while (!got && waited < csr_wait_lp)
      begin
         @(posedge clk_i);
         if (csr_rsp_v_o)
         begin
            got   = 1'b1;
            rdata = csr_rsp_data_o;
         end
         waited++;
      end
      if (!got)
      begin
         tb_errs++;
         $display("timeout waiting for a CSR response");
         finish_run();
      end
   endtask

   function automatic logic [31:0] reg_mask(input he_pkg::csr_addr_e reg_addr);
      case (reg_addr)
         he_pkg::CSR_Q: reg_mask = (32'h1 << `HE_COEF_W) - 1;
         he_pkg::CSR_N: reg_mask = (32'h1 << `HE_N_W) - 1;
         default:       reg_mask = 32'hffff_ffff;
      endcase
   endfunction

   // write all config registers first, then read back, so aliasing shows up
   task automatic check_csr_regs();
      he_pkg::csr_addr_e regs [5];
      logic [31:0]       vals [5];
      logic [31:0]       rd;
      regs = '{he_pkg::CSR_Q, he_pkg::CSR_N, he_pkg::CSR_A_PTR, he_pkg::CSR_B_PTR,
               he_pkg::CSR_WB_PTR};
      foreach (regs[i])
      begin
         vals[i] = $urandom();
         csr_xfer(1'b1, regs[i], vals[i], rd);
      end
      foreach (regs[i])
      begin
         csr_xfer(1'b0, regs[i], '0, rd);
         check_word($sformatf("csr_rsp_data_o[%s]", regs[i].name()), rd,
                    vals[i] & reg_mask(regs[i]));
      end
      csr_xfer(1'b0, he_pkg::csr_addr_e'(4'hf), '0, rd);
      check_word("csr_rsp_data_o[unknown]", rd, 32'h0);
   endtask

   task automatic wait_done();
      logic [31:0] status;
      int          polls;
      status = '0;
      polls  = 0;
      while (!status[1] && polls < done_polls_lp)
      begin
         csr_xfer(1'b0, he_pkg::CSR_STATUS, '0, status);
         polls++;
      end
      if (!status[1])
      begin
         tb_errs++;
         $display("timeout waiting for the run to finish");
         finish_run();
      end
   endtask

   ////////////////////////////////////////
   // one run of the adder

   task automatic run_case(input logic [31:0] a_ptr, input logic [31:0] b_ptr,
                           input logic [31:0] wb_ptr, input int n,
                           input logic [`HE_COEF_W-1:0] q, input logic restart);
      logic [`HE_COEF_W-1:0] a_vals [`HE_MAX_N];
      logic [`HE_COEF_W-1:0] b_vals [`HE_MAX_N];
      logic [`HE_ADDR_W-1:0] addr;
      logic [`HE_ADDR_W-1:0] wb_end;
      logic [63:0]           exp_sum;
      logic [31:0]           rd;
      int                    wb_writes;
      int                    irq_writes;
      for (int i = 0; i < n; i++)
      begin
         a_vals[i] = $urandom_range(q - 1, 0);
         b_vals[i] = $urandom_range(q - 1, 0);
         mem[a_ptr + `HE_COEF_STRIDE * i] = a_vals[i];
         mem[b_ptr + `HE_COEF_STRIDE * i] = b_vals[i];
         mem.delete(wb_ptr + `HE_COEF_STRIDE * i);
      end
      wr_log.delete();
      csr_xfer(1'b1, he_pkg::CSR_Q, q, rd);
      csr_xfer(1'b1, he_pkg::CSR_N, n, rd);
      csr_xfer(1'b1, he_pkg::CSR_A_PTR, a_ptr, rd);
      csr_xfer(1'b1, he_pkg::CSR_B_PTR, b_ptr, rd);
      csr_xfer(1'b1, he_pkg::CSR_WB_PTR, wb_ptr, rd);
      csr_xfer(1'b1, he_pkg::CSR_START, 32'h1, rd);
      if (restart)
      begin
         // a second start in the middle of the run must be dropped
         csr_xfer(1'b0, he_pkg::CSR_STATUS, '0, rd);
         check_true(rd[0], "STATUS did not show busy right after start");
         csr_xfer(1'b1, he_pkg::CSR_START, 32'h1, rd);
      end
      wait_done();
      csr_xfer(1'b0, he_pkg::CSR_STATUS, '0, rd);
      check_word("csr_rsp_data_o[STATUS]", rd, 32'h2);
      check_word("mem_cmd_o.wr (last)", last_cmd.wr, 1'b1);
      check_word("mem_cmd_o.addr (last)", last_cmd.addr, `HE_IRQ_ADDR);
      check_word("mem_cmd_o.data (last)", last_cmd.data, 32'hffff_ffff);
      for (int i = 0; i < n; i++)
      begin
         addr    = wb_ptr + `HE_COEF_STRIDE * i;
         exp_sum = (64'(a_vals[i]) + 64'(b_vals[i])) % q;
         check_word($sformatf("mem[%0h]", addr), read_word(addr), exp_sum);
      end
      wb_end     = wb_ptr + `HE_COEF_STRIDE * n;
      wb_writes  = 0;
      irq_writes = 0;
      foreach (wr_log[k])
      begin
         if (wr_log[k] == `HE_IRQ_ADDR)
            irq_writes++;
         else if (wr_log[k] >= wb_ptr && wr_log[k] < wb_end)
            wb_writes++;
         else
            check_true(1'b0, $sformatf("write outside the write-back area at %0h", wr_log[k]));
      end
      check_word("interrupt write count", irq_writes, 1);
      check_word("write-back write count", wb_writes, n);
   endtask

   initial
   begin
      void'($urandom(92));
      reset_i     = 1'b1;
      csr_v_i     = 1'b0;
      csr_req_i   = '0;
      mem_rsp_v_i = 1'b0;
      mem_rsp_i   = '0;
      tb_errs     = 0;
      repeat (16) @(posedge clk_i);
      reset_i <= 1'b0;
      check_csr_regs();
      run_case(32'h1000, 32'h2000, 32'h3000, 8, 30'd97, 1'b0);
      // full bank with q close to its upper limit
      run_case(32'h1_0000, 32'h1_1000, 32'h1_2000, `HE_MAX_N, 30'h3fff_fffd, 1'b1);
      run_case(32'h4000, 32'h5000, 32'h6000, 17, $urandom_range(32'h3fff_ffff, 2), 1'b0);
      finish_run();
   end

endmodule

`default_nettype wire

// ==== tests/he_accel_sva.sv ====
`default_nettype none

module he_accel_sva
(
   input logic clk_i,
   input logic reset_i,
   input logic csr_v_i,
   input logic csr_rsp_v_o,
   input logic mem_cmd_v_o,
   input logic mem_rsp_v_i
);

   int unsigned fail_cnt = 0;
   logic        mem_busy_r;
   logic        req_seen_r;

   // one memory command in flight, and whether any CSR request came yet
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         mem_busy_r <= 1'b0;
         req_seen_r <= 1'b0;
      end
      else
      begin
         if (mem_cmd_v_o)
            mem_busy_r <= 1'b1;
         else if (mem_rsp_v_i)
            mem_busy_r <= 1'b0;
         if (csr_v_i)
            req_seen_r <= 1'b1;
      end
   end

   csr_rsp_next: assert property (@(posedge clk_i) disable iff (reset_i)
      csr_v_i |=> csr_rsp_v_o)
   else
   begin
      fail_cnt++;
      $error("CSR request without a response on the next cycle");
   end

   mem_one_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_busy_r |-> !mem_cmd_v_o)
   else
   begin
      fail_cnt++;
      $error("memory command issued while a response is outstanding");
   end

   // quiet ports until software talks to the block
   quiet_after_reset: assert property (@(posedge clk_i) disable iff (reset_i)
      !req_seen_r |-> (!mem_cmd_v_o && !csr_rsp_v_o))
   else
   begin
      fail_cnt++;
      $error("output strobe before the first CSR request");
   end

endmodule

bind he_accel_top he_accel_sva sva_i
(
   .clk_i       (clk_i),
   .reset_i     (reset_i),
   .csr_v_i     (csr_v_i),
   .csr_rsp_v_o (csr_rsp_v_o),
   .mem_cmd_v_o (mem_cmd_v_o),
   .mem_rsp_v_i (mem_rsp_v_i)
);

`default_nettype wire

// ==== hw/he_accel_top.sv ====
`default_nettype none
`include "he_defs.svh"

module he_accel_top
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  csr_v_i,
   input  he_pkg::csr_req_s      csr_req_i,
   output logic                  csr_rsp_v_o,
   output logic [`HE_DATA_W-1:0] csr_rsp_data_o,
   output logic                  mem_cmd_v_o,
   output he_pkg::mem_cmd_s      mem_cmd_o,
   input  logic                  mem_rsp_v_i,
   input  he_pkg::mem_rsp_s      mem_rsp_i
);

   he_pkg::he_cfg_s       cfg;
   logic                  start;
   logic                  busy;
   logic                  done;
   logic                  dma_go;
   logic                  dma_done;
   he_pkg::dma_dir_e      dma_dir;
   logic [`HE_ADDR_W-1:0] dma_base;
   logic                  dma_cmd_v;
   he_pkg::mem_cmd_s      dma_cmd;
   logic                  irq_v;
   he_pkg::mem_cmd_s      irq_cmd;
   he_pkg::bank_sel_e     bank_sel;
   he_pkg::bank_wr_s      fill;
   he_pkg::bank_wr_s      add_res;
   he_pkg::bank_wr_s      wr_a;
   he_pkg::bank_wr_s      wr_b;
   logic                  dma_rd_v;
   logic [`HE_IDX_W-1:0]  dma_rd_idx;
   logic                  cmp_v;
   logic                  cmp_v_r;
   logic [`HE_IDX_W-1:0]  cmp_idx;
   logic [`HE_IDX_W-1:0]  cmp_idx_r;
   logic                  b_rd_v;
   logic [`HE_IDX_W-1:0]  b_rd_idx;
   logic [`HE_COEF_W-1:0] a_data;
   logic [`HE_COEF_W-1:0] b_data;

   he_csr_regs csr_i (.clk_i, .reset_i, .csr_v_i, .csr_req_i, .busy_i(busy), .done_i(done),
      .csr_rsp_v_o, .csr_rsp_data_o, .cfg_o(cfg), .start_o(start));

   he_sequencer seq_i (.clk_i, .reset_i, .start_i(start), .cfg_i(cfg), .dma_go_o(dma_go),
      .dma_dir_o(dma_dir), .dma_base_o(dma_base), .dma_done_i(dma_done),
      .bank_sel_o(bank_sel), .cmp_v_o(cmp_v), .cmp_idx_o(cmp_idx), .irq_v_o(irq_v),
      .irq_cmd_o(irq_cmd), .mem_rsp_v_i, .busy_o(busy), .done_o(done));

   he_dma_engine dma_i (.clk_i, .reset_i, .go_i(dma_go), .dir_i(dma_dir), .base_i(dma_base),
      .n_i(cfg.n), .mem_cmd_v_o(dma_cmd_v), .mem_cmd_o(dma_cmd), .mem_rsp_v_i, .mem_rsp_i,
      .fill_o(fill), .rd_v_o(dma_rd_v), .rd_idx_o(dma_rd_idx), .rd_data_i(b_data),
      .done_o(dma_done));

   ////////////////////////////////////////
   // bank write steering

   always_comb
   begin
      wr_a   = fill;
      wr_a.v = fill.v && (bank_sel == he_pkg::BANK_A);
      wr_b   = fill;
      wr_b.v = fill.v && (bank_sel == he_pkg::BANK_B);
      // sums overwrite bank B in place
      if (add_res.v)
         wr_b = add_res;
   end

   // compute and store never read bank B together
   assign b_rd_v   = cmp_v || dma_rd_v;
   assign b_rd_idx = cmp_v ? cmp_idx : dma_rd_idx;

   he_poly_bank bank_a (.clk_i, .wr_i(wr_a), .rd_v_i(cmp_v), .rd_idx_i(cmp_idx),
      .rd_data_o(a_data));

   he_poly_bank bank_b (.clk_i, .wr_i(wr_b), .rd_v_i(b_rd_v), .rd_idx_i(b_rd_idx),
      .rd_data_o(b_data));

   // line up valid and index with the bank read latency
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         cmp_v_r <= 1'b0;
      else
         cmp_v_r <= cmp_v;
      cmp_idx_r <= cmp_idx;
   end

   he_mod_add add_i (.clk_i, .reset_i, .v_i(cmp_v_r), .idx_i(cmp_idx_r), .a_i(a_data),
      .b_i(b_data), .q_i(cfg.q), .res_o(add_res));

   // the DMA engine is idle while the interrupt write goes out
   assign mem_cmd_v_o = dma_cmd_v || irq_v;
   assign mem_cmd_o   = irq_v ? irq_cmd : dma_cmd;

endmodule

`default_nettype wire

// ==== hw/he_sequencer.sv ====
`default_nettype none
`include "he_defs.svh"

module he_sequencer
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  start_i,
   input  he_pkg::he_cfg_s       cfg_i,
   output logic                  dma_go_o,
   output he_pkg::dma_dir_e      dma_dir_o,
   output logic [`HE_ADDR_W-1:0] dma_base_o,
   input  logic                  dma_done_i,
   output he_pkg::bank_sel_e     bank_sel_o,
   output logic                  cmp_v_o,
   output logic [`HE_IDX_W-1:0]  cmp_idx_o,
   output logic                  irq_v_o,
   output he_pkg::mem_cmd_s      irq_cmd_o,
   input  logic                  mem_rsp_v_i,
   output logic                  busy_o,
   output logic                  done_o
);

   // adder depth to wait out before write-back
   localparam int drain_cycles_lp = 2;

   he_pkg::seq_state_e state_r;
   logic [`HE_N_W-1:0] cnt_r;

   ////////////////////////////////////////
   // run FSM

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r  <= he_pkg::SEQ_IDLE;
         cnt_r    <= '0;
         dma_go_o <= 1'b0;
         done_o   <= 1'b0;
      end
      else
      begin
         dma_go_o <= 1'b0;
         case (state_r)
            // start is only taken here, so a start while busy is dropped
            he_pkg::SEQ_IDLE:
               if (start_i)
               begin
                  state_r  <= he_pkg::SEQ_LOAD_A;
                  dma_go_o <= 1'b1;
                  done_o   <= 1'b0;
               end
            he_pkg::SEQ_LOAD_A:
               if (dma_done_i)
               begin
                  state_r  <= he_pkg::SEQ_LOAD_B;
                  dma_go_o <= 1'b1;
               end
            he_pkg::SEQ_LOAD_B:
               if (dma_done_i)
               begin
                  state_r <= he_pkg::SEQ_COMPUTE;
                  cnt_r   <= '0;
               end
            he_pkg::SEQ_COMPUTE:
               if (cnt_r == cfg_i.n)
               begin
                  state_r <= he_pkg::SEQ_DRAIN;
                  cnt_r   <= '0;
               end
               else
                  cnt_r <= cnt_r + 1'b1;
            he_pkg::SEQ_DRAIN:
               if (cnt_r == drain_cycles_lp - 1)
               begin
                  state_r  <= he_pkg::SEQ_WRITE_BACK;
                  dma_go_o <= 1'b1;
               end
               else
                  cnt_r <= cnt_r + 1'b1;
            he_pkg::SEQ_WRITE_BACK:
               if (dma_done_i)
                  state_r <= he_pkg::SEQ_IRQ;
            he_pkg::SEQ_IRQ:
               state_r <= he_pkg::SEQ_IRQ_WAIT;
            he_pkg::SEQ_IRQ_WAIT:
               if (mem_rsp_v_i)
               begin
                  state_r <= he_pkg::SEQ_IDLE;
                  done_o  <= 1'b1;
               end
            default: state_r <= he_pkg::SEQ_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////
   // outputs from state

   always_comb
   begin
      dma_dir_o  = he_pkg::DMA_LOAD;
      dma_base_o = cfg_i.a_ptr;
      case (state_r)
         he_pkg::SEQ_LOAD_B: dma_base_o = cfg_i.b_ptr;
         he_pkg::SEQ_WRITE_BACK:
         begin
            dma_dir_o  = he_pkg::DMA_STORE;
            dma_base_o = cfg_i.wb_ptr;
         end
         default: ;
      endcase
   end

   assign bank_sel_o = (state_r == he_pkg::SEQ_LOAD_B) ? he_pkg::BANK_B : he_pkg::BANK_A;
   assign busy_o     = state_r != he_pkg::SEQ_IDLE;

   // one index per cycle and none on the extra cycle at cnt == n
   assign cmp_v_o    = (state_r == he_pkg::SEQ_COMPUTE) && (cnt_r != cfg_i.n);
   assign cmp_idx_o  = cnt_r[`HE_IDX_W-1:0];

   assign irq_v_o    = state_r == he_pkg::SEQ_IRQ;
   assign irq_cmd_o  = '{wr: 1'b1, addr: `HE_IRQ_ADDR, data: '1};

endmodule

`default_nettype wire

// ==== hw/he_mod_add.sv ====
`default_nettype none
`include "he_defs.svh"

module he_mod_add
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  v_i,
   input  logic [`HE_IDX_W-1:0]  idx_i,
   input  logic [`HE_COEF_W-1:0] a_i,
   input  logic [`HE_COEF_W-1:0] b_i,
   input  logic [`HE_COEF_W-1:0] q_i,
   output he_pkg::bank_wr_s      res_o
);

   logic                  s1_v;
   logic                  s2_v;
   logic [`HE_IDX_W-1:0]  s1_idx;
   logic [`HE_IDX_W-1:0]  s2_idx;
   logic [`HE_COEF_W:0]   s1_sum;
   logic [`HE_COEF_W:0]   s1_diff;
   logic [`HE_COEF_W-1:0] s2_coef;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         s1_v <= 1'b0;
         s2_v <= 1'b0;
      end
      else
      begin
         s1_v <= v_i;
         s2_v <= s1_v;
      end
   end

   // both inputs below q, so one subtraction is enough
   assign s1_diff = s1_sum - {1'b0, q_i};

   always_ff @(posedge clk_i)
   begin
      s1_idx  <= idx_i;
      s1_sum  <= a_i + b_i;
      s2_idx  <= s1_idx;
      s2_coef <= (s1_sum >= {1'b0, q_i}) ? s1_diff[`HE_COEF_W-1:0] : s1_sum[`HE_COEF_W-1:0];
   end

   assign res_o = '{v: s2_v, idx: s2_idx, coef: s2_coef};

endmodule

`default_nettype wire

// ==== hw/he_poly_bank.sv ====
`default_nettype none
`include "he_defs.svh"

module he_poly_bank
(
   input  logic                  clk_i,
   input  he_pkg::bank_wr_s      wr_i,
   input  logic                  rd_v_i,
   input  logic [`HE_IDX_W-1:0]  rd_idx_i,
   output logic [`HE_COEF_W-1:0] rd_data_o
);

   logic [`HE_COEF_W-1:0] mem_r [`HE_MAX_N];

   always_ff @(posedge clk_i)
   begin
      if (wr_i.v)
         mem_r[wr_i.idx] <= wr_i.coef;
   end

   // read data holds until the next read strobe
   always_ff @(posedge clk_i)
   begin
      if (rd_v_i)
         rd_data_o <= mem_r[rd_idx_i];
   end

endmodule

`default_nettype wire

// ==== hw/he_dma_engine.sv ====
`default_nettype none
`include "he_defs.svh"

module he_dma_engine
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  go_i,
   input  he_pkg::dma_dir_e      dir_i,
   input  logic [`HE_ADDR_W-1:0] base_i,
   input  logic [`HE_N_W-1:0]    n_i,
   output logic                  mem_cmd_v_o,
   output he_pkg::mem_cmd_s      mem_cmd_o,
   input  logic                  mem_rsp_v_i,
   input  he_pkg::mem_rsp_s      mem_rsp_i,
   output he_pkg::bank_wr_s      fill_o,
   output logic                  rd_v_o,
   output logic [`HE_IDX_W-1:0]  rd_idx_o,
   input  logic [`HE_COEF_W-1:0] rd_data_i,
   output logic                  done_o
);

   typedef enum logic [1:0] {DMA_IDLE, DMA_ISSUE, DMA_WAIT} dma_state_e;

   dma_state_e            state_r;
   he_pkg::dma_dir_e      dir_r;
   logic [`HE_ADDR_W-1:0] base_r;
   logic [`HE_ADDR_W-1:0] offset;
   logic [`HE_N_W-1:0]    n_r;
   logic [`HE_N_W-1:0]    cnt_inc;
   logic [`HE_IDX_W-1:0]  cnt_r;
   logic                  rsp_v;
   logic                  last;
   logic                  to_issue;
   logic                  store_nxt;

   assign rsp_v   = (state_r == DMA_WAIT) && mem_rsp_v_i;
   assign cnt_inc = cnt_r + 1'b1;
   assign last    = cnt_inc == n_r;
   assign offset  = cnt_r * `HE_COEF_STRIDE;

   // cycle before each command; a store reads its coefficient here
   assign to_issue  = (state_r == DMA_IDLE) ? (go_i && n_i != '0) : (rsp_v && !last);
   assign store_nxt = (state_r == DMA_IDLE) ? (dir_i == he_pkg::DMA_STORE) :
                                              (dir_r == he_pkg::DMA_STORE);
   assign rd_v_o    = to_issue && store_nxt;
   assign rd_idx_o  = (state_r == DMA_IDLE) ? '0 : cnt_r + 1'b1;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= DMA_IDLE;
         done_o  <= 1'b0;
      end
      else
      begin
         done_o <= 1'b0;
         case (state_r)
            DMA_IDLE:
               if (go_i)
               begin
                  // empty block finishes at once
                  if (n_i == '0)
                     done_o <= 1'b1;
                  else
                     state_r <= DMA_ISSUE;
               end
            DMA_ISSUE: state_r <= DMA_WAIT;
            DMA_WAIT:
               if (mem_rsp_v_i)
               begin
                  state_r <= last ? DMA_IDLE : DMA_ISSUE;
                  done_o  <= last;
               end
            default: state_r <= DMA_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (state_r == DMA_IDLE && go_i)
      begin
         dir_r  <= dir_i;
         base_r <= base_i;
         n_r    <= n_i;
         cnt_r  <= '0;
      end
      else if (rsp_v)
         cnt_r <= cnt_r + 1'b1;
   end

   assign mem_cmd_v_o    = state_r == DMA_ISSUE;
   assign mem_cmd_o.wr   = dir_r == he_pkg::DMA_STORE;
   assign mem_cmd_o.addr = base_r + offset;
   assign mem_cmd_o.data = mem_cmd_o.wr ? {{(`HE_DATA_W-`HE_COEF_W){1'b0}}, rd_data_i} : '0;

   // load responses go straight into the selected bank
   assign fill_o.v    = rsp_v && (dir_r == he_pkg::DMA_LOAD);
   assign fill_o.idx  = cnt_r;
   assign fill_o.coef = mem_rsp_i.data[`HE_COEF_W-1:0];

endmodule

`default_nettype wire

// ==== hw/he_csr_regs.sv ====
`default_nettype none
`include "he_defs.svh"

module he_csr_regs
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  csr_v_i,
   input  he_pkg::csr_req_s      csr_req_i,
   input  logic                  busy_i,
   input  logic                  done_i,
   output logic                  csr_rsp_v_o,
   output logic [`HE_DATA_W-1:0] csr_rsp_data_o,
   output he_pkg::he_cfg_s       cfg_o,
   output logic                  start_o
);

   logic                  wr_v;
   logic                  start_hit;
   logic [`HE_DATA_W-1:0] rd_data;

   assign wr_v      = csr_v_i && csr_req_i.wr;
   assign start_hit = wr_v && (csr_req_i.addr == he_pkg::CSR_START);

   ////////////////////////////////////////
   // configuration writes

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         cfg_o       <= '0;
         start_o     <= 1'b0;
         csr_rsp_v_o <= 1'b0;
      end
      else
      begin
         // every request gets its answer on the next cycle
         csr_rsp_v_o <= csr_v_i;
         start_o     <= start_hit && csr_req_i.data[0];
         if (wr_v)
         begin
            case (csr_req_i.addr)
               he_pkg::CSR_Q:      cfg_o.q      <= csr_req_i.data[`HE_COEF_W-1:0];
               he_pkg::CSR_N:      cfg_o.n      <= csr_req_i.data[`HE_N_W-1:0];
               he_pkg::CSR_A_PTR:  cfg_o.a_ptr  <= `HE_ADDR_W'(csr_req_i.data);
               he_pkg::CSR_B_PTR:  cfg_o.b_ptr  <= `HE_ADDR_W'(csr_req_i.data);
               he_pkg::CSR_WB_PTR: cfg_o.wb_ptr <= `HE_ADDR_W'(csr_req_i.data);
               default:            ;
            endcase
         end
      end
   end

   ////////////////////////////////////////
   // read mux

   always_comb
   begin
      rd_data = '0;
      if (!csr_req_i.wr)
      begin
         case (csr_req_i.addr)
            he_pkg::CSR_Q:      rd_data[`HE_COEF_W-1:0] = cfg_o.q;
            he_pkg::CSR_N:      rd_data[`HE_N_W-1:0]    = cfg_o.n;
            he_pkg::CSR_A_PTR:  rd_data = cfg_o.a_ptr[`HE_DATA_W-1:0];
            he_pkg::CSR_B_PTR:  rd_data = cfg_o.b_ptr[`HE_DATA_W-1:0];
            he_pkg::CSR_WB_PTR: rd_data = cfg_o.wb_ptr[`HE_DATA_W-1:0];
            // busy in bit 0, done in bit 1
            he_pkg::CSR_STATUS: rd_data[1:0] = {done_i, busy_i};
            default:            rd_data = '0;
         endcase
      end
   end

   // write responses carry zero
   always_ff @(posedge clk_i)
   begin
      if (csr_v_i)
         csr_rsp_data_o <= rd_data;
   end

endmodule

`default_nettype wire

// ==== hw/he_pkg.sv ====
`default_nettype none
`include "he_defs.svh"

package he_pkg;

   // CSR index map
   typedef enum logic [`HE_CSR_ADDR_W-1:0]
   {
      CSR_Q,
      CSR_N,
      CSR_A_PTR,
      CSR_B_PTR,
      CSR_WB_PTR,
      CSR_START,
      CSR_STATUS
   } csr_addr_e;

   typedef struct packed
   {
      logic                  wr;
      csr_addr_e             addr;
      logic [`HE_DATA_W-1:0] data;
   } csr_req_s;

   // one command on the memory port that writes when wr is set
   typedef struct packed
   {
      logic                  wr;
      logic [`HE_ADDR_W-1:0] addr;
      logic [`HE_DATA_W-1:0] data;
   } mem_cmd_s;

   typedef struct packed
   {
      logic [`HE_DATA_W-1:0] data;
   } mem_rsp_s;

   // write into a coefficient bank
   typedef struct packed
   {
      logic                  v;
      logic [`HE_IDX_W-1:0]  idx;
      logic [`HE_COEF_W-1:0] coef;
   } bank_wr_s;

   typedef enum logic {DMA_LOAD, DMA_STORE} dma_dir_e;

   typedef enum logic {BANK_A, BANK_B} bank_sel_e;

   typedef enum logic [2:0]
   {
      SEQ_IDLE,
      SEQ_LOAD_A,
      SEQ_LOAD_B,
      SEQ_COMPUTE,
      SEQ_DRAIN,
      SEQ_WRITE_BACK,
      SEQ_IRQ,
      SEQ_IRQ_WAIT
   } seq_state_e;

   // run configuration as held in the CSR block
   typedef struct packed
   {
      logic [`HE_COEF_W-1:0] q;
      logic [`HE_N_W-1:0]    n;
      logic [`HE_ADDR_W-1:0] a_ptr;
      logic [`HE_ADDR_W-1:0] b_ptr;
      logic [`HE_ADDR_W-1:0] wb_ptr;
   } he_cfg_s;

endpackage

`default_nettype wire

// ==== include/he_defs.svh ====
`ifndef HE_DEFS_SVH
`define HE_DEFS_SVH

// bus and register data width
`define HE_DATA_W 32
`define HE_ADDR_W 40

// coefficients and the modulus share one width
`define HE_COEF_W 30

// bank depth and the index and length widths it implies
`define HE_MAX_N 64
`define HE_IDX_W ($clog2(`HE_MAX_N))
`define HE_N_W (`HE_IDX_W + 1)

// byte step between coefficients in memory
`define HE_COEF_STRIDE 4

`define HE_IRQ_ADDR 40'h30_0000
`define HE_CSR_ADDR_W 4

`endif
